// File: detector_pkg.sv
package detector_pkg;

    // number of error terms summed per hypothesis
    localparam int SEQ_LENGTH = 3;

    localparam int NUM_PATTERNS  = 4;
    localparam int PATTERN_DEPTH = 3;

    // bit f set means the decision f positions after the lane is flipped
    localparam logic [PATTERN_DEPTH-1:0] FLIP_PATTERNS [0:NUM_PATTERNS-1] = '{
        3'b001,
        3'b011,
        3'b111,
        3'b101
    };

    // one id per pattern plus the no-flip case
    localparam int FLAG_W = $clog2(NUM_PATTERNS + 1);

    // register stages inside the sliding detector
    localparam int DETECT_LATENCY = 2;

    // id 0 keeps the decisions, id n flips with pattern n-1
    typedef enum logic [FLAG_W-1:0] {
        FLIP_NONE = 0,
        FLIP_P0   = 1,
        FLIP_P1   = 2,
        FLIP_P2   = 3,
        FLIP_P3   = 4
    } flip_id_t;

endpackage

// File: dsp_pkg.sv
package dsp_pkg;

    // lanes per frame, one sliced bit and one residual error each
    localparam int LANES = 4;

    // signed residual error precision
    localparam int ERR_W = 8;

    // channel estimate, signed taps
    localparam int CHAN_W     = 8;
    localparam int CHAN_DEPTH = 3;

    // holds the worst-case sum of squares over the window without saturation
    localparam int ENER_W = 22;

    // register stages around the detector
    localparam int IN_PIPE_DEPTH  = 1;
    localparam int OUT_PIPE_DEPTH = 1;

endpackage

// File: error_checker_checker.sv
`timescale 1ns/100ps

module error_checker_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_valid,
    input logic                   out_valid,
    input detector_pkg::flip_id_t sd_flags [dsp_pkg::LANES-1:0]
);
    import dsp_pkg::*;
    import detector_pkg::*;

    // registers between frame acceptance and the result
    localparam int TOTAL_LATENCY = IN_PIPE_DEPTH + DETECT_LATENCY + OUT_PIPE_DEPTH;

    // read by the testbench
    int assert_failures = 0;

    // one reset cycle clears every valid stage
    assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high after a reset cycle");
            assert_failures++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
        else begin
            $error("out_valid is unknown outside reset");
            assert_failures++;
        end

    for (genvar gi = 0; gi < LANES; gi++) begin : g_flag_range
        assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> sd_flags[gi] <= FLIP_P3)
            else begin
                $error("sd_flags lane %0d holds an id past FLIP_P3", gi);
                assert_failures++;
            end
    end

    // a result is always launched by an accepted frame
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, TOTAL_LATENCY))
        else begin
            $error("out_valid without an accepted frame %0d cycles earlier", TOTAL_LATENCY);
            assert_failures++;
        end

endmodule

// File: error_checker_datapath.sv
`timescale 1ns/100ps

module error_checker_datapath (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic [dsp_pkg::LANES-1:0]          sliced_bits,
    input  logic signed [dsp_pkg::ERR_W-1:0]   res_errors [dsp_pkg::LANES-1:0],
    input  logic signed [dsp_pkg::CHAN_W-1:0]  channel_est [dsp_pkg::CHAN_DEPTH-1:0],
    output logic                               out_valid,
    output detector_pkg::flip_id_t             sd_flags [dsp_pkg::LANES-1:0],
    output logic [dsp_pkg::ENER_W-1:0]         sd_flags_ener [dsp_pkg::LANES-1:0],
    output logic [dsp_pkg::LANES-1:0]          sliced_bits_out,
    output logic signed [dsp_pkg::ERR_W-1:0]   res_errors_out [dsp_pkg::LANES-1:0]
);
    import dsp_pkg::*;
    import detector_pkg::*;

    // input side, raw lane vectors
    logic [0:0]        bits_in_lanes [LANES-1:0];
    logic [ERR_W-1:0]  errs_in_raw   [LANES-1:0];
    logic [0:0]        bits_dl_out   [LANES-1:0];
    logic [ERR_W-1:0]  errs_dl_out   [LANES-1:0];
    logic              bits_dl_valid;

    // detector boundary
    logic [LANES-1:0]        det_bits;
    logic signed [ERR_W-1:0] det_errors [LANES-1:0];
    logic                    det_valid;
    flip_id_t                det_flags [LANES-1:0];
    logic [ENER_W-1:0]       det_ener  [LANES-1:0];
    logic [LANES-1:0]        det_judged_bits;
    logic signed [ERR_W-1:0] det_judged_errors [LANES-1:0];

    // output side
    logic [FLAG_W-1:0] flags_raw       [LANES-1:0];
    logic [0:0]        judged_bits_raw [LANES-1:0];
    logic [ERR_W-1:0]  judged_errs_raw [LANES-1:0];
    logic [FLAG_W-1:0] flags_dl_out    [LANES-1:0];
    logic [0:0]        bits_out_dl     [LANES-1:0];
    logic [ERR_W-1:0]  errs_out_dl     [LANES-1:0];

    for (genvar gi = 0; gi < LANES; gi++) begin : g_lane_map
        assign bits_in_lanes[gi]   = sliced_bits[gi];
        assign errs_in_raw[gi]     = $unsigned(res_errors[gi]);
        assign det_bits[gi]        = bits_dl_out[gi];
        assign det_errors[gi]      = $signed(errs_dl_out[gi]);
        assign flags_raw[gi]       = det_flags[gi];
        assign judged_bits_raw[gi] = det_judged_bits[gi];
        assign judged_errs_raw[gi] = $unsigned(det_judged_errors[gi]);
        assign sd_flags[gi]        = flip_id_t'(flags_dl_out[gi]);
        assign sliced_bits_out[gi] = bits_out_dl[gi];
        assign res_errors_out[gi]  = $signed(errs_out_dl[gi]);
    end

    // bits lane carries the valid used by the detector
    lane_delay_line #(.WIDTH(1), .DEPTH(IN_PIPE_DEPTH)) i_bits_in_dl (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .data_in(bits_in_lanes),
        .out_valid(bits_dl_valid), .data_out(bits_dl_out)
    );

    lane_delay_line #(.WIDTH(ERR_W), .DEPTH(IN_PIPE_DEPTH)) i_errs_in_dl (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .data_in(errs_in_raw),
        .out_valid(), .data_out(errs_dl_out)
    );

    sliding_detector i_sliding_detector (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (bits_dl_valid),
        .sliced_bits   (det_bits),
        .res_errors    (det_errors),
        .channel_est   (channel_est),
        .out_valid     (det_valid),
        .flags         (det_flags),
        .energies      (det_ener),
        .judged_bits   (det_judged_bits),
        .judged_errors (det_judged_errors)
    );

    // the flags lane drives out_valid for the whole result
    lane_delay_line #(.WIDTH(FLAG_W), .DEPTH(OUT_PIPE_DEPTH)) i_flags_out_dl (
        .clk(clk), .rst_n(rst_n), .in_valid(det_valid), .data_in(flags_raw),
        .out_valid(out_valid), .data_out(flags_dl_out)
    );

    lane_delay_line #(.WIDTH(ENER_W), .DEPTH(OUT_PIPE_DEPTH)) i_ener_out_dl (
        .clk(clk), .rst_n(rst_n), .in_valid(det_valid), .data_in(det_ener),
        .out_valid(), .data_out(sd_flags_ener)
    );

    lane_delay_line #(.WIDTH(1), .DEPTH(OUT_PIPE_DEPTH)) i_bits_out_dl (
        .clk(clk), .rst_n(rst_n), .in_valid(det_valid), .data_in(judged_bits_raw),
        .out_valid(), .data_out(bits_out_dl)
    );

    lane_delay_line #(.WIDTH(ERR_W), .DEPTH(OUT_PIPE_DEPTH)) i_errs_out_dl (
        .clk(clk), .rst_n(rst_n), .in_valid(det_valid), .data_in(judged_errs_raw),
        .out_valid(), .data_out(errs_out_dl)
    );

endmodule

// File: error_checker_tb.sv
`timescale 1ns/100ps

module error_checker_tb;
    import dsp_pkg::*;
    import detector_pkg::*;

    localparam int ZERO_FRAMES   = 8;
    localparam int PLANT_FRAMES  = 9;
    localparam int RANDOM_FRAMES = 200;
    localparam int GAP_FRAMES    = 100;
    localparam int RESET_FRAMES  = 20;
    localparam int TAPS_FRAMES   = 100;
    localparam int TOTAL_FRAMES  = ZERO_FRAMES + PLANT_FRAMES + RANDOM_FRAMES + GAP_FRAMES
                                 + RESET_FRAMES + TAPS_FRAMES;
    localparam int CYCLE_LIMIT   = 20 * TOTAL_FRAMES + 100;

    // flipped offsets per pattern, P0 to P3
    localparam bit FLIP_OFFSETS [NUM_PATTERNS][PATTERN_DEPTH] = '{
        '{1, 0, 0},
        '{1, 1, 0},
        '{1, 1, 1},
        '{1, 0, 1}
    };

    typedef struct {
        flip_id_t                flags [LANES-1:0];
        logic [ENER_W-1:0]       ener  [LANES-1:0];
        logic [LANES-1:0]        bits;
        logic signed [ERR_W-1:0] errs  [LANES-1:0];
        int                      planted_lane;
        flip_id_t                planted_id;
        bit                      clean;
    } judged_t;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic [LANES-1:0]         sliced_bits;
    logic signed [ERR_W-1:0]  res_errors [LANES-1:0];
    logic signed [CHAN_W-1:0] channel_est [CHAN_DEPTH-1:0];
    logic                     out_valid;
    flip_id_t                 sd_flags [LANES-1:0];
    logic [ENER_W-1:0]        sd_flags_ener [LANES-1:0];
    logic [LANES-1:0]         sliced_bits_out;
    logic signed [ERR_W-1:0]  res_errors_out [LANES-1:0];

    judged_t                 expected_q [$];
    logic [LANES-1:0]        prev_bits;
    logic signed [ERR_W-1:0] prev_errs [LANES-1:0];
    int                      prev_planted_lane;
    flip_id_t                prev_planted_id;
    bit                      prev_clean;
    bit                      have_prev;
    int                      accepted;
    int                      received;
    int                      cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(10)) i_tb_clock_gen (.clk(clk));

    error_checker_datapath i_error_checker_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .sliced_bits     (sliced_bits),
        .res_errors      (res_errors),
        .channel_est     (channel_est),
        .out_valid       (out_valid),
        .sd_flags        (sd_flags),
        .sd_flags_ener   (sd_flags_ener),
        .sliced_bits_out (sliced_bits_out),
        .res_errors_out  (res_errors_out)
    );

    bind error_checker_datapath error_checker_checker i_checker (.*);

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // window of old frame then new frame, every hypothesis per lane
    function automatic judged_t judge_pair(
        input logic [LANES-1:0]         old_bits,
        input logic signed [ERR_W-1:0]  old_errs [LANES-1:0],
        input logic [LANES-1:0]         new_bits,
        input logic signed [ERR_W-1:0]  new_errs [LANES-1:0],
        input logic signed [CHAN_W-1:0] taps [CHAN_DEPTH-1:0]
    );
        judged_t r;
        int      sym [2*LANES];
        int      err [2*LANES];
        int      ener;
        int      best;
        int      e_mod;
        for (int j = 0; j < LANES; j++) begin
            sym[j]         = old_bits[j] ? 1 : -1;
            sym[LANES + j] = new_bits[j] ? 1 : -1;
            err[j]         = old_errs[j];
            err[LANES + j] = new_errs[j];
        end
        for (int i = 0; i < LANES; i++) begin
            best = -1;
            for (int id = 0; id <= NUM_PATTERNS; id++) begin
                ener = 0;
                for (int m = 0; m < SEQ_LENGTH; m++) begin
                    e_mod = err[i + m];
                    for (int f = 0; f < PATTERN_DEPTH; f++) begin
                        if (id > 0 && FLIP_OFFSETS[id-1][f] && f <= m && m - f < CHAN_DEPTH) begin
                            e_mod += 2 * sym[i + f] * taps[m - f];
                        end
                    end
                    ener += e_mod * e_mod;
                end
                // strict compare, lower id wins a tie
                if (best < 0 || ener < best) begin
                    best       = ener;
                    r.flags[i] = flip_id_t'(id);
                end
            end
            r.ener[i] = ENER_W'(best);
        end
        r.bits         = old_bits;
        r.errs         = old_errs;
        r.planted_lane = -1;
        r.planted_id   = FLIP_NONE;
        r.clean        = 1'b0;
        return r;
    endfunction

    task automatic check_flags(input int lane, input flip_id_t want, input flip_id_t got);
        if (got !== want) begin
            $display("FAIL sd_flags[%0d] expected %h got %h", lane, want, got);
            stop_run();
        end
    endtask

    task automatic check_energy(input int lane, input logic [ENER_W-1:0] want,
                                input logic [ENER_W-1:0] got);
        if (got !== want) begin
            $display("FAIL sd_flags_ener[%0d] expected %h got %h", lane, want, got);
            stop_run();
        end
    endtask

    task automatic check_data(input int lane, input logic want_bit, input logic got_bit,
                              input logic signed [ERR_W-1:0] want_err,
                              input logic signed [ERR_W-1:0] got_err);
        if (got_bit !== want_bit) begin
            $display("FAIL sliced_bits_out[%0d] expected %h got %h", lane, want_bit, got_bit);
            stop_run();
        end
        if (got_err !== want_err) begin
            $display("FAIL res_errors_out[%0d] expected %h got %h", lane, want_err, got_err);
            stop_run();
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n    = 1'b0;
        in_valid = 1'b0;
        repeat (4) @(negedge clk);
        // in-flight results are gone, pairing restarts
        expected_q.delete();
        have_prev = 1'b0;
        accepted  = 0;
        received  = 0;
        rst_n     = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid    = 1'b0;
            sliced_bits = LANES'($urandom);
            for (int j = 0; j < LANES; j++) begin
                res_errors[j] = ERR_W'($urandom);
            end
        end
    endtask

    task automatic random_frame(output logic [LANES-1:0] bits,
                                output logic signed [ERR_W-1:0] errs [LANES-1:0]);
        bits = LANES'($urandom);
        for (int j = 0; j < LANES; j++) begin
            errs[j] = ERR_W'($urandom);
        end
    endtask

    // residuals that a decision error under pattern pat at lane would leave
    task automatic plant_frame(input int lane, input int pat, output logic [LANES-1:0] bits,
                               output logic signed [ERR_W-1:0] errs [LANES-1:0]);
        int acc;
        int sym;
        bits = LANES'($urandom);
        for (int j = 0; j < LANES; j++) begin
            errs[j] = '0;
        end
        for (int m = 0; m < SEQ_LENGTH; m++) begin
            acc = 0;
            for (int f = 0; f < PATTERN_DEPTH; f++) begin
                if (FLIP_OFFSETS[pat][f] && f <= m && m - f < CHAN_DEPTH) begin
                    sym = bits[lane + f] ? 1 : -1;
                    acc += 2 * sym * channel_est[m - f];
                end
            end
            errs[lane + m] = ERR_W'(-acc);
        end
    endtask

    task automatic send_frame(input logic [LANES-1:0] bits,
                              input logic signed [ERR_W-1:0] errs [LANES-1:0],
                              input int planted_lane, input flip_id_t planted_id,
                              input bit clean);
        judged_t r;
        @(negedge clk);
        in_valid    = 1'b1;
        sliced_bits = bits;
        res_errors  = errs;
        accepted++;
        // this frame completes the window of the previous one
        if (have_prev) begin
            r = judge_pair(prev_bits, prev_errs, bits, errs, channel_est);
            r.planted_lane = prev_planted_lane;
            r.planted_id   = prev_planted_id;
            r.clean        = prev_clean;
            expected_q.push_back(r);
        end
        prev_bits         = bits;
        prev_errs         = errs;
        prev_planted_lane = planted_lane;
        prev_planted_id   = planted_id;
        prev_clean        = clean;
        have_prev         = 1'b1;
    endtask

    task automatic drain_pipeline();
        // fixed latency of the last result plus a margin for any stray result
        idle_cycles(2 * (IN_PIPE_DEPTH + DETECT_LATENCY + OUT_PIPE_DEPTH) + 1);
    endtask

    function automatic bit count_ok();
        return received == accepted - 1;
    endfunction

    task automatic finish_section(input string name);
        drain_pipeline();
        if (!count_ok()) begin
            $display("result count wrong after %s: %0d results for %0d frames",
                     name, received, accepted);
            stop_run();
        end
    endtask

    initial begin : stimulus
        logic [LANES-1:0]        bits;
        logic signed [ERR_W-1:0] errs [LANES-1:0];
        void'($urandom(8));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        sliced_bits = '0;
        for (int j = 0; j < LANES; j++) begin
            res_errors[j] = '0;
        end
        channel_est[0] = 8'sd20;
        channel_est[1] = -8'sd9;
        channel_est[2] = 8'sd5;
        have_prev = 1'b0;
        accepted  = 0;
        received  = 0;

        // zero residuals, any flip only adds energy
        apply_reset();
        for (int n = 0; n < ZERO_FRAMES; n++) begin
            random_frame(bits, errs);
            for (int j = 0; j < LANES; j++) begin
                errs[j] = '0;
            end
            send_frame(bits, errs, -1, FLIP_NONE, 1'b1);
        end
        finish_section("zero residual frames");

        // planted decision errors on lanes 0 and 1
        apply_reset();
        for (int n = 0; n < PLANT_FRAMES - 1; n++) begin
            plant_frame(n % 2, (n / 2) % NUM_PATTERNS, bits, errs);
            send_frame(bits, errs, n % 2, flip_id_t'((n / 2) % NUM_PATTERNS + 1), 1'b0);
        end
        random_frame(bits, errs);
        send_frame(bits, errs, -1, FLIP_NONE, 1'b0);
        finish_section("planted errors");

        for (int k = 0; k < CHAN_DEPTH; k++) begin
            channel_est[k] = CHAN_W'($urandom);
        end
        apply_reset();
        for (int n = 0; n < RANDOM_FRAMES; n++) begin
            random_frame(bits, errs);
            send_frame(bits, errs, -1, FLIP_NONE, 1'b0);
        end
        finish_section("random frames");

        // gaps in in_valid
        apply_reset();
        for (int n = 0; n < GAP_FRAMES; n++) begin
            random_frame(bits, errs);
            send_frame(bits, errs, -1, FLIP_NONE, 1'b0);
            idle_cycles($urandom_range(3));
        end
        finish_section("frames with gaps");

        // reset while frames are still in flight
        apply_reset();
        for (int n = 0; n < RESET_FRAMES / 2; n++) begin
            random_frame(bits, errs);
            send_frame(bits, errs, -1, FLIP_NONE, 1'b0);
        end
        apply_reset();
        for (int n = 0; n < RESET_FRAMES / 2; n++) begin
            random_frame(bits, errs);
            send_frame(bits, errs, -1, FLIP_NONE, 1'b0);
        end
        finish_section("reset in mid run");

        // second phase, taps change on an empty pipeline
        for (int k = 0; k < CHAN_DEPTH; k++) begin
            channel_est[k] = CHAN_W'($urandom);
        end
        apply_reset();
        for (int n = 0; n < TAPS_FRAMES; n++) begin
            random_frame(bits, errs);
            send_frame(bits, errs, -1, FLIP_NONE, 1'b0);
            idle_cycles($urandom_range(1));
        end
        drain_pipeline();
        if (!count_ok()) begin
            $display("result count wrong after new taps: %0d results for %0d frames",
                     received, accepted);
            stop_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // outputs are registered, stable at the falling edge
    initial begin : compare_results
        judged_t want;
        forever begin
            @(negedge clk);
            if (out_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("out_valid went high with no frame waiting to be judged");
                    stop_run();
                end else begin
                    want = expected_q.pop_front();
                    for (int i = 0; i < LANES; i++) begin
                        check_flags(i, want.flags[i], sd_flags[i]);
                        check_energy(i, want.ener[i], sd_flags_ener[i]);
                        check_data(i, want.bits[i], sliced_bits_out[i], want.errs[i],
                                   res_errors_out[i]);
                        if (want.clean) begin
                            check_flags(i, FLIP_NONE, sd_flags[i]);
                            check_energy(i, '0, sd_flags_ener[i]);
                        end
                    end
                    // the planted pattern cancels its window completely
                    if (want.planted_lane >= 0) begin
                        check_flags(want.planted_lane, want.planted_id,
                                    sd_flags[want.planted_lane]);
                        check_energy(want.planted_lane, '0, sd_flags_ener[want.planted_lane]);
                    end
                    received++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (i_error_checker_datapath.i_checker.assert_failures != 0) begin
            $display("a concurrent assertion on the DUT failed");
            stop_run();
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

endmodule

// File: flip_energy_lane.sv
`timescale 1ns/100ps

module flip_energy_lane (
    input  logic [2*dsp_pkg::LANES-1:0]        window_bits,
    input  logic signed [dsp_pkg::ERR_W-1:0]   window_errors [2*dsp_pkg::LANES-1:0],
    input  logic signed [dsp_pkg::CHAN_W-1:0]  channel_est [dsp_pkg::CHAN_DEPTH-1:0],
    input  logic [$clog2(dsp_pkg::LANES)-1:0]  lane_base,
    output detector_pkg::flip_id_t             flag,
    output logic [dsp_pkg::ENER_W-1:0]         energy
);
    import dsp_pkg::*;
    import detector_pkg::*;

    // hypothesis 0 is the unmodified window, hypothesis h uses pattern h-1
    localparam int NUM_HYP = NUM_PATTERNS + 1;

    // error plus a few doubled taps, wide enough to square in place
    localparam int WORK_W = 2 * (CHAN_W + 4);

    logic [PATTERN_DEPTH-1:0]  hyp_mask;
    logic signed [WORK_W-1:0]  mod_err;
    logic signed [WORK_W-1:0]  tap_x2;
    logic [WORK_W-1:0]         err_sq;
    logic [ENER_W-1:0]         hyp_acc;
    logic [ENER_W-1:0]         hyp_ener [NUM_HYP-1:0];
    logic [ENER_W-1:0]         best_ener;
    logic [FLAG_W-1:0]         best_id;

    // energy of every flip hypothesis over positions lane_base .. lane_base+SEQ_LENGTH-1
    always_comb begin
        hyp_mask = '0;
        mod_err  = '0;
        tap_x2   = '0;
        err_sq   = '0;
        hyp_acc  = '0;
        for (int h = 0; h < NUM_HYP; h++) begin
            hyp_mask = '0;
            if (h > 0) begin
                hyp_mask = FLIP_PATTERNS[h-1];
            end
            hyp_acc = '0;
            for (int m = 0; m < SEQ_LENGTH; m++) begin
                mod_err = WORK_W'(window_errors[lane_base + m]);
                // a flip at offset f reaches error m through tap m-f
                for (int f = 0; f < PATTERN_DEPTH; f++) begin
                    if (hyp_mask[f] && (f <= m) && (m - f < CHAN_DEPTH)) begin
                        tap_x2 = WORK_W'(channel_est[m - f]) <<< 1;
                        if (window_bits[lane_base + f]) begin
                            mod_err = mod_err + tap_x2;
                        end else begin
                            mod_err = mod_err - tap_x2;
                        end
                    end
                end
                err_sq  = mod_err * mod_err;
                hyp_acc = hyp_acc + err_sq[ENER_W-1:0];
            end
            hyp_ener[h] = hyp_acc;
        end
    end

    // minimum search, strict compare keeps the lower id on a tie
    always_comb begin
        best_ener = hyp_ener[0];
        best_id   = '0;
        for (int h = 1; h < NUM_HYP; h++) begin
            if (hyp_ener[h] < best_ener) begin
                best_ener = hyp_ener[h];
                best_id   = FLAG_W'(h);
            end
        end
    end

    assign flag   = flip_id_t'(best_id);
    assign energy = best_ener;

endmodule

// File: lane_delay_line.sv
`timescale 1ns/100ps

module lane_delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] data_in [dsp_pkg::LANES-1:0],
    output logic             out_valid,
    output logic [WIDTH-1:0] data_out [dsp_pkg::LANES-1:0]
);
    import dsp_pkg::*;

    logic [WIDTH-1:0] pipe_data [DEPTH-1:0][LANES-1:0];
    logic [DEPTH-1:0] pipe_valid;

    // valid marker travels next to the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= in_valid;
            for (int d = 1; d < DEPTH; d++) begin
                pipe_valid[d] <= pipe_valid[d-1];
            end
        end
    end

    // payload shifts every cycle
    always_ff @(posedge clk) begin
        pipe_data[0] <= data_in;
        for (int d = 1; d < DEPTH; d++) begin
            pipe_data[d] <= pipe_data[d-1];
        end
    end

    assign out_valid = pipe_valid[DEPTH-1];
    assign data_out  = pipe_data[DEPTH-1];

endmodule

// File: sliding_detector.sv
`timescale 1ns/100ps

module sliding_detector (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic [dsp_pkg::LANES-1:0]          sliced_bits,
    input  logic signed [dsp_pkg::ERR_W-1:0]   res_errors [dsp_pkg::LANES-1:0],
    input  logic signed [dsp_pkg::CHAN_W-1:0]  channel_est [dsp_pkg::CHAN_DEPTH-1:0],
    output logic                               out_valid,
    output detector_pkg::flip_id_t             flags [dsp_pkg::LANES-1:0],
    output logic [dsp_pkg::ENER_W-1:0]         energies [dsp_pkg::LANES-1:0],
    output logic [dsp_pkg::LANES-1:0]          judged_bits,
    output logic signed [dsp_pkg::ERR_W-1:0]   judged_errors [dsp_pkg::LANES-1:0]
);
    import dsp_pkg::*;
    import detector_pkg::*;

    localparam int LANE_IDX_W = $clog2(LANES);

    // last accepted frame
    logic [LANES-1:0]        prev_bits;
    logic signed [ERR_W-1:0] prev_errors [LANES-1:0];
    logic                    have_prev;

    logic [2*LANES-1:0]      win_bits;
    logic signed [ERR_W-1:0] win_errors [2*LANES-1:0];
    logic                    window_valid;

    flip_id_t                lane_flag [LANES-1:0];
    logic [ENER_W-1:0]       lane_ener [LANES-1:0];

    // index 0 is stage 1
    logic [DETECT_LATENCY-1:0] stage_valid;
    flip_id_t                  stage_flags  [DETECT_LATENCY-1:0][LANES-1:0];
    logic [ENER_W-1:0]         stage_ener   [DETECT_LATENCY-1:0][LANES-1:0];
    logic [LANES-1:0]          stage_bits   [DETECT_LATENCY-1:0];
    logic signed [ERR_W-1:0]   stage_errors [DETECT_LATENCY-1:0][LANES-1:0];

    // older frame in the low positions
    assign win_bits     = {sliced_bits, prev_bits};
    assign window_valid = in_valid && have_prev;

    for (genvar gi = 0; gi < LANES; gi++) begin : g_lane
        assign win_errors[gi]         = prev_errors[gi];
        assign win_errors[LANES + gi] = res_errors[gi];

        flip_energy_lane i_flip_energy_lane (
            .window_bits   (win_bits),
            .window_errors (win_errors),
            .channel_est   (channel_est),
            .lane_base     (LANE_IDX_W'(gi)),
            .flag          (lane_flag[gi]),
            .energy        (lane_ener[gi])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_prev   <= 1'b0;
            stage_valid <= '0;
        end else begin
            if (in_valid) begin
                have_prev <= 1'b1;
            end
            stage_valid[0] <= window_valid;
            for (int s = 1; s < DETECT_LATENCY; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // stage 1 pairs the result with the frame it judges
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prev_bits   <= sliced_bits;
            prev_errors <= res_errors;
        end
        stage_flags[0]  <= lane_flag;
        stage_ener[0]   <= lane_ener;
        stage_bits[0]   <= prev_bits;
        stage_errors[0] <= prev_errors;
        for (int s = 1; s < DETECT_LATENCY; s++) begin
            stage_flags[s]  <= stage_flags[s-1];
            stage_ener[s]   <= stage_ener[s-1];
            stage_bits[s]   <= stage_bits[s-1];
            stage_errors[s] <= stage_errors[s-1];
        end
    end

    assign out_valid     = stage_valid[DETECT_LATENCY-1];
    assign flags         = stage_flags[DETECT_LATENCY-1];
    assign energies      = stage_ener[DETECT_LATENCY-1];
    assign judged_bits   = stage_bits[DETECT_LATENCY-1];
    assign judged_errors = stage_errors[DETECT_LATENCY-1];

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    // free-running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: verilog.f
dsp_pkg.sv
detector_pkg.sv
lane_delay_line.sv
flip_energy_lane.sv
sliding_detector.sv
error_checker_datapath.sv
tb_clock_gen.sv
error_checker_checker.sv
error_checker_tb.sv
